// ==== common/audio_pkg.sv ====
// Audio mixing path definitions

package audio_pkg;

	// Sample and datapath widths
	localparam int SAMPLE_W = 16;
	localparam int ACC_W = 17;

	// Bit 4 mutes, bits 3..0 hold the right shift
	localparam int ATT_W = 5;

	// Host command codes
	localparam logic [7:0] CMD_VOLUME = 8'h26;

	//////////////////////////////////////////////////
	// Crossfeed modes
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

	// One stereo sample pair
	typedef struct packed {
		logic [SAMPLE_W-1:0] left;
		logic [SAMPLE_W-1:0] right;
	} stereo_sample_t;

	//////////////////////////////////////////////////
	// Wishbone classic host bus
	//////////////////////////////////////////////////

	// adr 0 selects the command register, adr 1 the data register
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic        adr;
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

endpackage

// ==== design/host_cmd_port.sv ====
// Host command port

`timescale 1ns/10ps

module host_cmd_port (
	input  logic                          clk,
	input  logic                          resetd,
	input  audio_pkg::wb_req_t            i_wb,
	output audio_pkg::wb_rsp_t            o_wb,
	output logic [audio_pkg::ATT_W-1:0]   o_att
);
	import audio_pkg::*;

	localparam int DW = $bits(i_wb.dat);

	logic             ack_q;
	logic             has_cmd;
	logic [7:0]       cmd_q;
	logic [ATT_W-1:0] att_q;
	logic             accept;
	logic             wr_cmd;
	logic             wr_data;

	// A new cycle is taken only while ack is low, so ack lasts one clock
	assign accept = i_wb.cyc & i_wb.stb & ~ack_q;
	assign wr_cmd = accept & i_wb.we & ~i_wb.adr;
	assign wr_data = accept & i_wb.we & i_wb.adr;

	//////////////////////////////////////////////////
	// Bus handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	//////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////

	// A command byte replaces whatever command came before
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd_q <= '0;
		end else if (wr_cmd) begin
			has_cmd <= 1'b1;
			cmd_q <= i_wb.dat[7:0];
		end
	end

	// Data words for other commands fall through untouched
	always_ff @(posedge clk) begin
		if (resetd) begin
			att_q <= '0;
		end else if (wr_data && has_cmd && (cmd_q == CMD_VOLUME)) begin
			att_q <= i_wb.dat[ATT_W-1:0];
		end
	end

	// Both addresses read back the attenuation
	assign o_wb = '{ack: ack_q, dat: {{(DW-ATT_W){1'b0}}, att_q}};
	assign o_att = att_q;

	// One-clock ack pulse
	a_ack_single: assert property (
		@(posedge clk) disable iff (resetd)
		ack_q |=> !ack_q
	) else $error("ack held high for more than one clock");

	// Ack only answers a cycle the master had open
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (resetd)
		ack_q |-> $past(i_wb.cyc)
	) else $error("ack without a bus cycle on the previous clock");

endmodule

// ==== audio/sample_stabilizer.sv ====
// Core audio glitch filter

`timescale 1ns/10ps

module sample_stabilizer #(
	parameter int DEPTH_STABLE = 2
) (
	input  logic                      clk,
	input  logic                      resetd,
	input  audio_pkg::stereo_sample_t i_sample,
	output audio_pkg::stereo_sample_t o_sample
);
	import audio_pkg::*;

	// Copy 0 catches the raw input, the rest are compared
	stereo_sample_t chain [DEPTH_STABLE+1];
	stereo_sample_t out_q;
	logic           stable;

	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i <= DEPTH_STABLE; i++) begin
				chain[i] <= '0;
			end
		end else begin
			chain[0] <= i_sample;
			for (int i = 1; i <= DEPTH_STABLE; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	always_comb begin
		stable = 1'b1;
		for (int i = 2; i <= DEPTH_STABLE; i++) begin
			if (chain[i] != chain[1]) begin
				stable = 1'b0;
			end
		end
	end

	// Hold the last accepted pair while copies disagree
	always_ff @(posedge clk) begin
		if (resetd) begin
			out_q <= '0;
		end else if (stable) begin
			out_q <= chain[1];
		end
	end

	assign o_sample = out_q;

endmodule

// ==== audio/channel_mixer.sv ====
// Single channel audio mixer

`timescale 1ns/10ps

module channel_mixer (
	input  logic                            clk,
	input  logic                            resetd,
	input  logic [audio_pkg::SAMPLE_W-1:0]  i_core,
	input  logic [audio_pkg::SAMPLE_W-1:0]  i_pcm,
	input  logic [audio_pkg::SAMPLE_W-1:0]  i_pre_other,
	input  logic                            i_is_signed,
	input  audio_pkg::mix_mode_t            i_mix,
	input  logic [audio_pkg::ATT_W-1:0]     i_att,
	output logic [audio_pkg::SAMPLE_W-1:0]  o_pre,
	output logic [audio_pkg::SAMPLE_W-1:0]  o_out
);
	import audio_pkg::*;

	logic signed [ACC_W-1:0] a1;
	logic [SAMPLE_W-1:0]     pcm_q;
	logic signed [ACC_W-1:0] a2;
	logic signed [ACC_W-1:0] a3;
	logic signed [ACC_W-1:0] a4;
	logic [SAMPLE_W-1:0]     out_q;
	logic signed [ACC_W-1:0] pcm_ext;
	logic signed [ACC_W-1:0] pre_ext;
	logic signed [ACC_W-1:0] xfeed;

	assign pcm_ext = {pcm_q[SAMPLE_W-1], pcm_q};
	assign pre_ext = {i_pre_other[SAMPLE_W-1], i_pre_other};

	//////////////////////////////////////////////////
	// Crossfeed select
	//////////////////////////////////////////////////

	// The other channel's pre value lines up with our own stage 2
	always_comb begin
		case (i_mix)
			MIX_25:   xfeed = a2 - (a2 >>> 3) + (pre_ext >>> 2);
			MIX_50:   xfeed = a2 - (a2 >>> 2) + (pre_ext >>> 1);
			MIX_MONO: xfeed = (a2 >>> 1) + pre_ext;
			default:  xfeed = a2;
		endcase
	end

	//////////////////////////////////////////////////
	// Five stage pipeline
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1 <= '0;
			pcm_q <= '0;
			a2 <= '0;
			a3 <= '0;
			a4 <= '0;
			out_q <= '0;
		end else begin
			// Stage 1, unsigned audio loses its LSB to stay positive
			if (i_is_signed) begin
				a1 <= {i_core[SAMPLE_W-1], i_core};
			end else begin
				a1 <= {2'b00, i_core[SAMPLE_W-1:1]};
			end
			pcm_q <= i_pcm;

			// Stage 2
			a2 <= a1 + pcm_ext;

			// Stage 3
			a3 <= xfeed;

			// Stage 4, volume
			if (i_att[ATT_W-1]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[ATT_W-2:0];
			end

			// Stage 5, clamp to the 16-bit range
			if (a4[ACC_W-1] ^ a4[ACC_W-2]) begin
				out_q <= {a4[ACC_W-1], {(SAMPLE_W-1){~a4[ACC_W-1]}}};
			end else begin
				out_q <= a4[SAMPLE_W-1:0];
			end
		end
	end

	assign o_pre = a2[ACC_W-1:1];
	assign o_out = out_q;

	// Reset flushes the whole pipe, not only the output register
	a_reset_out: assert property (
		@(posedge clk)
		resetd |=> (o_out == '0) [*5]
	) else $error("mixer output not cleared after reset");

endmodule

// ==== design/audio_mix_top.sv ====
// Stereo audio mix top level

`timescale 1ns/10ps

module audio_mix_top #(
	parameter int DEPTH_STABLE = 2
) (
	input  logic                      clk,
	input  logic                      resetd,
	input  audio_pkg::wb_req_t        i_wb,
	output audio_pkg::wb_rsp_t        o_wb,
	input  audio_pkg::stereo_sample_t i_core,
	input  logic                      i_is_signed,
	input  audio_pkg::mix_mode_t      i_mix,
	input  audio_pkg::stereo_sample_t i_pcm,
	output audio_pkg::stereo_sample_t o_audio
);
	import audio_pkg::*;

	logic [ATT_W-1:0]    att;
	stereo_sample_t      core_stable;
	logic [SAMPLE_W-1:0] pre_l;
	logic [SAMPLE_W-1:0] pre_r;
	logic [SAMPLE_W-1:0] out_l;
	logic [SAMPLE_W-1:0] out_r;

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	host_cmd_port u_cmd (
		.clk    (clk),
		.resetd (resetd),
		.i_wb   (i_wb),
		.o_wb   (o_wb),
		.o_att  (att)
	);

	//////////////////////////////////////////////////
	// Audio path
	//////////////////////////////////////////////////

	sample_stabilizer #(
		.DEPTH_STABLE (DEPTH_STABLE)
	) u_stab (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core),
		.o_sample (core_stable)
	);

	// Pre values cross over between the two channels
	channel_mixer u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (core_stable.left),
		.i_pcm       (i_pcm.left),
		.i_pre_other (pre_r),
		.i_is_signed (i_is_signed),
		.i_mix       (i_mix),
		.i_att       (att),
		.o_pre       (pre_l),
		.o_out       (out_l)
	);

	channel_mixer u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (core_stable.right),
		.i_pcm       (i_pcm.right),
		.i_pre_other (pre_l),
		.i_is_signed (i_is_signed),
		.i_mix       (i_mix),
		.i_att       (att),
		.o_pre       (pre_r),
		.o_out       (out_r)
	);

	assign o_audio = '{left: out_l, right: out_r};

endmodule

// ==== tb/tb_audio_mix.sv ====
// Audio mix testbench

`timescale 1ns/10ps

module tb_audio_mix;
	import audio_pkg::*;

	localparam int HOLD_CLKS = 12;
	localparam int RESET_CLKS = 16;
	// Vectors per attenuation in the plain mix block, two of them saturate
	localparam int N_NONE = 8;
	localparam int N_XFEED = 6;
	localparam int N_UNSIGNED = 8;
	localparam int N_VECTORS = 3 * N_NONE + 3 * N_XFEED + N_UNSIGNED + 3 + 1;
	localparam int TIMEOUT_CLKS = N_VECTORS * HOLD_CLKS * 2 + 500;

	logic           clk = 1'b0;
	logic           resetd;
	wb_req_t        wb_req;
	wb_rsp_t        wb_rsp;
	stereo_sample_t core;
	logic           is_signed;
	mix_mode_t      mix;
	stereo_sample_t pcm;
	stereo_sample_t audio;

	logic [31:0]    lcg_state = 32'hd23a;
	logic [4:0]     att_model = 5'd0;
	stereo_sample_t exp_audio;
	string          vec_name;
	int             n_applied = 0;
	int             n_checked = 0;
	int             value_errors = 0;
	int             bus_errors = 0;
	int             cycle_cnt = 0;

	audio_mix_top #(
		.DEPTH_STABLE (2)
	) UUT (
		.clk         (clk),
		.resetd      (resetd),
		.i_wb        (wb_req),
		.o_wb        (wb_rsp),
		.i_core      (core),
		.i_is_signed (is_signed),
		.i_mix       (mix),
		.i_pcm       (pcm),
		.o_audio     (audio)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Two's complement wrap to the 17-bit accumulator
	function automatic int wrap_17(input int v);
		logic signed [16:0] t;
		t = v[16:0];
		return t;
	endfunction

	// Conversion plus PCM sum
	function automatic int sum_front(input logic [15:0] c, input logic [15:0] p,
			input logic sgn);
		int cv;
		if (sgn) begin
			cv = $signed(c);
		end else begin
			cv = c >> 1;
		end
		return wrap_17(cv + $signed(p));
	endfunction

	// Crossfeed, volume and clamp for one channel
	function automatic logic [15:0] finish_channel(input int own, input int other,
			input mix_mode_t m, input logic [4:0] att);
		int pre;
		int x;
		int v;
		pre = other >>> 1;
		case (m)
			MIX_25:   x = own - (own >>> 3) + (pre >>> 2);
			MIX_50:   x = own - (own >>> 2) + (pre >>> 1);
			MIX_MONO: x = (own >>> 1) + pre;
			default:  x = own;
		endcase
		x = wrap_17(x);
		if (att[4]) begin
			v = 0;
		end else begin
			v = x >>> att[3:0];
		end
		if (v > 32767) begin
			return 16'h7fff;
		end else if (v < -32768) begin
			return 16'h8000;
		end
		return v[15:0];
	endfunction

	function automatic stereo_sample_t ref_mix(input stereo_sample_t c,
			input stereo_sample_t p, input logic sgn, input mix_mode_t m,
			input logic [4:0] att);
		stereo_sample_t r;
		int sum_l;
		int sum_r;
		sum_l = sum_front(c.left, p.left, sgn);
		sum_r = sum_front(c.right, p.right, sgn);
		r.left = finish_channel(sum_l, sum_r, m, att);
		r.right = finish_channel(sum_r, sum_l, m, att);
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic logic [15:0] lcg_rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic stereo_sample_t rand_pair();
		stereo_sample_t s;
		s.left = lcg_rand16();
		s.right = lcg_rand16();
		return s;
	endfunction

	function automatic stereo_sample_t pair_of(input logic [15:0] l, input logic [15:0] r);
		stereo_sample_t s;
		s.left = l;
		s.right = r;
		return s;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	// One Wishbone classic cycle, the master holds the request until ack
	task automatic bus_cycle(input logic we, input logic adr, input logic [15:0] dat,
			output logic [15:0] rdata);
		int waited;
		logic got;
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		got = 1'b0;
		waited = 0;
		rdata = '0;
		while (!got && waited < 4) begin
			@(negedge clk);
			waited++;
			if (wb_rsp.ack) begin
				got = 1'b1;
				rdata = wb_rsp.dat;
			end
		end
		if (!got) begin
			$display("Bus error at %0t: no ack within 4 clocks", $time);
			bus_errors++;
		end else begin
			// Request stays up one clock past ack, which must still fall
			@(negedge clk);
			if (wb_rsp.ack) begin
				$display("Bus error at %0t: ack stayed high after the cycle", $time);
				bus_errors++;
			end
		end
		wb_req = '0;
	endtask

	task automatic set_volume(input logic [4:0] att);
		logic [15:0] rd;
		bus_cycle(1'b1, 1'b0, {8'h00, CMD_VOLUME}, rd);
		bus_cycle(1'b1, 1'b1, {11'h000, att}, rd);
		att_model = att;
	endtask

	task automatic readback_check(input logic adr, input string what);
		logic [15:0] rd;
		bus_cycle(1'b0, adr, 16'h0000, rd);
		check_equal({16'h0000, rd}, {27'h0, att_model}, what);
	endtask

	// Hands one vector to the comparing process and waits for its verdict
	task automatic apply_vector(input stereo_sample_t c, input stereo_sample_t p,
			input logic sgn, input mix_mode_t m, input string what);
		@(negedge clk);
		core = c;
		pcm = p;
		is_signed = sgn;
		mix = m;
		exp_audio = ref_mix(c, p, sgn, m, att_model);
		vec_name = what;
		n_applied++;
		wait (n_checked == n_applied);
	endtask

	task automatic run_mode_block(input mix_mode_t m, input logic sgn, input int n,
			input string what);
		for (int i = 0; i < n; i++) begin
			apply_vector(rand_pair(), rand_pair(), sgn, m, $sformatf("%s %0d", what, i));
		end
	endtask

	task automatic run_none_block(input logic [4:0] att);
		set_volume(att);
		apply_vector(pair_of(16'h7fff, 16'h8000), pair_of(16'h7fff, 16'h8000), 1'b1,
			MIX_NONE, "full scale saturate");
		apply_vector(pair_of(16'h4000, 16'hc000), pair_of(16'h4001, 16'hbfff), 1'b1,
			MIX_NONE, "edge saturate");
		run_mode_block(MIX_NONE, 1'b1, N_NONE - 2, $sformatf("none att %0d", att));
	endtask

	//////////////////////////////////////////////////
	// Comparing process and watchdog
	//////////////////////////////////////////////////

	always begin
		wait (n_applied != n_checked);
		repeat (HOLD_CLKS) @(negedge clk);
		check_equal(audio, exp_audio, vec_name);
		n_checked++;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CLKS) begin
			$display("Timeout after %0d clocks, the test did not finish", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [15:0]    rd;
		stereo_sample_t steady;
		int             waited;
		resetd = 1'b1;
		wb_req = '0;
		core = '0;
		pcm = '0;
		is_signed = 1'b1;
		mix = MIX_NONE;
		repeat (RESET_CLKS) @(negedge clk);
		resetd = 1'b0;

		// Reset state and register access
		@(negedge clk);
		check_equal(audio, 32'h0, "audio after reset");
		check_equal({31'h0, wb_rsp.ack}, 32'h0, "ack after reset");
		bus_cycle(1'b1, 1'b0, {8'h00, CMD_VOLUME}, rd);
		bus_cycle(1'b1, 1'b1, 16'hffea, rd);
		att_model = 5'h0a;
		readback_check(1'b1, "volume readback data reg");
		bus_cycle(1'b1, 1'b1, 16'h0013, rd);
		att_model = 5'h13;
		readback_check(1'b0, "volume readback cmd reg");
		bus_cycle(1'b1, 1'b0, 16'h0011, rd);
		bus_cycle(1'b1, 1'b1, 16'h0005, rd);
		readback_check(1'b1, "data under other command");

		// Plain mix, signed core, several volumes
		run_none_block(5'd0);
		run_none_block(5'd3);
		run_none_block(5'd15);

		// Crossfeed modes
		set_volume(5'd1);
		run_mode_block(MIX_25, 1'b1, N_XFEED, "mix 25");
		run_mode_block(MIX_50, 1'b1, N_XFEED, "mix 50");
		run_mode_block(MIX_MONO, 1'b1, N_XFEED, "mix mono");

		// Unsigned core audio
		set_volume(5'd0);
		run_mode_block(MIX_NONE, 1'b0, N_UNSIGNED / 4, "unsigned none");
		run_mode_block(MIX_25, 1'b0, N_UNSIGNED / 4, "unsigned 25");
		run_mode_block(MIX_50, 1'b0, N_UNSIGNED / 4, "unsigned 50");
		run_mode_block(MIX_MONO, 1'b0, N_UNSIGNED / 4, "unsigned mono");

		// Mute while a nonzero sample is held
		apply_vector(pair_of(16'h1234, 16'hedcc), pair_of(16'h0100, 16'h0200), 1'b1,
			MIX_NONE, "before mute");
		set_volume(5'h10);
		waited = 0;
		while (audio !== 32'h0 && waited < HOLD_CLKS) begin
			@(negedge clk);
			waited++;
		end
		check_equal(audio, 32'h0, "mute after ack");
		apply_vector(rand_pair(), rand_pair(), 1'b1, MIX_MONO, "muted mono");
		apply_vector(rand_pair(), rand_pair(), 1'b1, MIX_50, "muted 50");

		// Single clock glitch on the core input
		set_volume(5'd0);
		steady = pair_of(16'h2345, 16'hd0f0);
		apply_vector(steady, pair_of(16'h0011, 16'hff00), 1'b1, MIX_NONE, "glitch base");
		@(negedge clk);
		core = pair_of(16'h5a5a, 16'h0f0f);
		@(negedge clk);
		core = steady;
		for (int k = 0; k < HOLD_CLKS; k++) begin
			@(negedge clk);
			check_equal(audio, exp_audio, $sformatf("glitch hold clock %0d", k));
		end

		$display("Errors: %0d value mismatches, %0d bus faults over %0d vectors",
			value_errors, bus_errors, n_checked);
		if (value_errors == 0 && bus_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
common/audio_pkg.sv
design/host_cmd_port.sv
audio/sample_stabilizer.sv
audio/channel_mixer.sv
design/audio_mix_top.sv
tb/tb_audio_mix.sv

// ==== Bender.yml ====
package:
  name: audio_mix

sources:
  # Package before every user of its types
  - common/audio_pkg.sv

  # Host command port and audio path
  - design/host_cmd_port.sv
  - audio/sample_stabilizer.sv
  - audio/channel_mixer.sv

  # Top level
  - design/audio_mix_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_audio_mix.sv
